// File: Makefile
TOP := audio_player_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: common/fifo_if.sv
`timescale 1ns/1ns

interface fifo_if;
    import stream_pkg::*;

    logic    push;        // write strobe, one byte per cycle
    logic    pop;         // advances head on the following edge
    logic    empty;
    logic    level_low;   // room for a whole sector
    logic    level_high;  // enough buffered to start playing
    sample_t push_data;
    sample_t head;        // show-ahead byte, valid while !empty

    modport producer (output push, output push_data,
                      input level_low, input level_high, input empty);
    modport consumer (output pop, input head, input empty);
    modport store    (input push, input push_data, input pop,
                      output head, output empty, output level_low, output level_high);

endinterface

// File: common/player_pkg.sv
package player_pkg;

    localparam int NUM_SONGS = 4;   // fixed song table size

    typedef logic [1:0]  song_idx_t;
    typedef logic [31:0] sector_t;    // sd block address
    typedef logic [7:0]  blk_cnt_t;   // sectors per song

    localparam int BLOCK_BYTES = 512;
    typedef logic [8:0] byte_cnt_t;   // wraps to 0 after byte 511

    // first sector of each song
    localparam sector_t SONG_START [NUM_SONGS] = '{
        32'd100,
        32'd200,
        32'd300,
        32'd400
    };

    // length of each song in sectors
    localparam blk_cnt_t SONG_BLOCKS [NUM_SONGS] = '{
        8'd2,
        8'd3,
        8'd1,
        8'd4
    };

    typedef enum logic [1:0] {
        IDLE,    // menu active, nothing requested
        FILL,    // reading sectors, waiting for the high mark
        STREAM,  // reading and sending frames
        DRAIN    // song fully read, emptying the fifo
    } play_state_t;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

    localparam int SAMPLE_BITS = 8;
    typedef logic [SAMPLE_BITS-1:0] sample_t;   // one audio byte

    localparam int FRAME_BITS = 24;
    typedef logic [FRAME_BITS-1:0] frame_t;
    localparam int SYNC_BITS = 4;
    localparam logic [SYNC_BITS-1:0] SYNC_WORD = 4'b1011;   // sent msb first
    localparam int PAD_BITS = FRAME_BITS - SYNC_BITS - SAMPLE_BITS;   // trailing zeros, 12
    typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;

    localparam int BIT_DIV = 2;   // clocks per serial bit
    typedef logic [$clog2(BIT_DIV)-1:0] div_cnt_t;

    localparam int FIFO_DEPTH = 1024;
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_level_t;   // 0 .. FIFO_DEPTH

    // a sector still fits at or below this fill
    localparam fifo_level_t FIFO_LOW = 11'd512;
    // streaming may start at or above this fill
    localparam fifo_level_t FIFO_HIGH = 11'd768;

endpackage

// File: design/audio_player.sv
`timescale 1ns/1ns

module audio_player (
    input  logic                  clk_25mhz,
    input  logic                  rst,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  logic                  btn_select,
    input  stream_pkg::sample_t   sd_byte,
    input  logic                  sd_byte_valid,
    output logic                  block_req,
    output player_pkg::sector_t   block_addr,
    output player_pkg::song_idx_t song_index,
    output logic                  playing,
    output logic                  serial_out
);

    logic play_req;    // select strobe into the controller
    logic stream_en;   // frames run while high

    fifo_if fifo ();

    song_menu u_menu (
        .clk_25mhz  (clk_25mhz),
        .rst        (rst),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_select (btn_select),
        .busy       (playing),      // menu frozen during playback
        .song_index (song_index),
        .play_req   (play_req)
    );

    playback_ctrl u_ctrl (
        .clk_25mhz     (clk_25mhz),
        .rst           (rst),
        .play_req      (play_req),
        .song_sel      (song_index),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .fifo          (fifo),
        .block_req     (block_req),
        .block_addr    (block_addr),
        .busy          (playing),
        .stream_en     (stream_en)
    );

    sample_fifo u_fifo (
        .clk_25mhz (clk_25mhz),
        .rst       (rst),
        .fifo      (fifo)
    );

    frame_assembler u_frame (
        .clk_25mhz  (clk_25mhz),
        .rst        (rst),
        .stream_en  (stream_en),
        .fifo       (fifo),
        .serial_out (serial_out)
    );

endmodule

// File: design/frame_assembler.sv
`timescale 1ns/1ns

module frame_assembler (
    input  logic     clk_25mhz,
    input  logic     rst,
    input  logic     stream_en,
    fifo_if.consumer fifo,
    output logic     serial_out
);
    import stream_pkg::*;

    logic     active;     // frame in progress
    div_cnt_t div_cnt;    // clocks within the current bit
    bit_cnt_t bit_cnt;    // bit position within the frame
    frame_t   shreg;      // outgoing frame, msb on the line
    logic     bit_end;
    logic     boundary;
    sample_t  data_sel;
    sample_t  data_rev;

    assign bit_end  = (div_cnt == div_cnt_t'(BIT_DIV - 1));
    assign boundary = !active || (bit_end && (bit_cnt == bit_cnt_t'(FRAME_BITS - 1)));

    assign fifo.pop   = boundary && stream_en && !fifo.empty;
    assign data_sel   = fifo.empty ? '0 : fifo.head;   // underrun sends silence
    assign serial_out = shreg[FRAME_BITS-1];

    // data goes out lsb first
    always_comb begin
        for (int i = 0; i < SAMPLE_BITS; i++) begin
            data_rev[i] = data_sel[SAMPLE_BITS-1-i];
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            active  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else if (boundary) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            active  <= stream_en;
            if (stream_en) begin
                shreg <= {SYNC_WORD, data_rev, {PAD_BITS{1'b0}}};   // sync on the line next cycle
            end else begin
                shreg <= '0;   // idle line stays low
            end
        end else if (bit_end) begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            shreg   <= {shreg[FRAME_BITS-2:0], 1'b0};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// File: design/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
    parameter int DEPTH = stream_pkg::FIFO_DEPTH
) (
    input logic   clk_25mhz,
    input logic   rst,
    fifo_if.store fifo
);
    import stream_pkg::*;

    localparam int AW = $clog2(DEPTH);

    sample_t       mem [DEPTH];
    logic [AW-1:0] wr_ptr;   // both pointers wrap at DEPTH
    logic [AW-1:0] rd_ptr;
    fifo_level_t   count;    // bytes held

    assign fifo.head       = mem[rd_ptr];   // show-ahead read
    assign fifo.empty      = (count == '0);
    assign fifo.level_low  = (count <= FIFO_LOW);
    assign fifo.level_high = (count >= FIFO_HIGH);

    // byte storage
    always_ff @(posedge clk_25mhz) begin
        if (fifo.push) begin
            mem[wr_ptr] <= fifo.push_data;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo.push, fifo.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// File: flist.f
common/player_pkg.sv
common/stream_pkg.sv
common/fifo_if.sv
playback/song_menu.sv
playback/playback_ctrl.sv
design/sample_fifo.sv
design/frame_assembler.sv
design/audio_player.sv
verification/audio_player_tb.sv

// File: playback/playback_ctrl.sv
`timescale 1ns/1ns

module playback_ctrl (
    input  logic                  clk_25mhz,
    input  logic                  rst,
    input  logic                  play_req,
    input  player_pkg::song_idx_t song_sel,
    input  stream_pkg::sample_t   sd_byte,
    input  logic                  sd_byte_valid,
    fifo_if.producer              fifo,
    output logic                  block_req,
    output player_pkg::sector_t   block_addr,
    output logic                  busy,
    output logic                  stream_en
);
    import player_pkg::*;

    play_state_t state;
    blk_cnt_t    blocks_left;       // sectors still to be requested
    sector_t     next_addr;         // address of the next request
    logic        waiting_for_data;  // a sector is outstanding
    byte_cnt_t   byte_cnt;          // bytes received in the current sector
    logic        start;
    logic        accept;
    logic        block_done;
    logic        song_read;
    logic        all_read;
    logic        issue;

    assign start  = (state == IDLE) && play_req;
    assign accept = waiting_for_data && sd_byte_valid;   // stray bytes are dropped

    // 512th byte closes the sector
    assign block_done = accept && (byte_cnt == byte_cnt_t'(BLOCK_BYTES - 1));
    assign song_read  = block_done && (blocks_left == '0);   // last sector just finished
    assign all_read   = !waiting_for_data && (blocks_left == '0);

    // one sector at a time, and only when it fits
    assign issue = ((state == FILL) || (state == STREAM)) && !waiting_for_data
                   && (blocks_left != '0) && fifo.level_low;

    assign fifo.push      = accept;   // pushed in the cycle it arrives
    assign fifo.push_data = sd_byte;
    assign busy           = (state != IDLE);
    assign stream_en      = (state == STREAM) || (state == DRAIN);

    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            state            <= IDLE;
            block_req        <= 1'b0;
            waiting_for_data <= 1'b0;
            byte_cnt         <= '0;
            blocks_left      <= '0;
        end else begin
            block_req <= 1'b0;
            if (accept) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (block_done) begin
                waiting_for_data <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (play_req) begin
                        state            <= FILL;
                        block_req        <= 1'b1;   // first sector right away
                        waiting_for_data <= 1'b1;
                        byte_cnt         <= '0;
                        blocks_left      <= SONG_BLOCKS[song_sel] - 1'b1;
                    end
                end
                FILL: begin
                    if (fifo.level_high || song_read) begin
                        state <= STREAM;   // short songs start without the high mark
                    end
                end
                STREAM: begin
                    if (song_read || all_read) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (fifo.empty) begin
                        state <= IDLE;   // last frame still finishes in the assembler
                    end
                end
                default: state <= IDLE;
            endcase

            if (issue) begin
                block_req        <= 1'b1;
                waiting_for_data <= 1'b1;
                blocks_left      <= blocks_left - 1'b1;
            end
        end
    end

    // sector addresses walk up from the song's first sector
    always_ff @(posedge clk_25mhz) begin
        if (start) begin
            block_addr <= SONG_START[song_sel];
            next_addr  <= SONG_START[song_sel] + 1'b1;
        end else if (issue) begin
            block_addr <= next_addr;
            next_addr  <= next_addr + 1'b1;
        end
    end

endmodule

// File: playback/song_menu.sv
`timescale 1ns/1ns

module song_menu (
    input  logic                  clk_25mhz,
    input  logic                  rst,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  logic                  btn_select,
    input  logic                  busy,
    output player_pkg::song_idx_t song_index,
    output logic                  play_req
);
    import player_pkg::*;

    logic prev_up;       // button levels from the last edge
    logic prev_down;
    logic prev_select;
    logic up_rise;
    logic down_rise;
    logic select_rise;

    // buttons count only while nothing is playing
    assign up_rise     = btn_up && !prev_up && !busy;
    assign down_rise   = btn_down && !prev_down && !busy;
    assign select_rise = btn_select && !prev_select && !busy;

    always_ff @(posedge clk_25mhz) begin
        if (rst) begin
            prev_up     <= 1'b0;
            prev_down   <= 1'b0;
            prev_select <= 1'b0;
            song_index  <= '0;
            play_req    <= 1'b0;
        end else begin
            prev_up     <= btn_up;
            prev_down   <= btn_down;
            prev_select <= btn_select;
            play_req    <= select_rise;   // one cycle strobe
            if (up_rise) begin
                song_index <= (song_index == song_idx_t'(NUM_SONGS - 1)) ? '0 : song_index + 1'b1;
            end else if (down_rise) begin
                song_index <= (song_index == '0) ? song_idx_t'(NUM_SONGS - 1) : song_index - 1'b1;
            end
        end
    end

endmodule

// File: verification/audio_player_tb.sv
`timescale 1ns/1ns

module audio_player_tb;
    import player_pkg::*;
    import stream_pkg::*;

    localparam int CLK_NS     = 40;
    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_SELECT = 2;
    localparam int NUM_ROWS   = 4;

    typedef struct packed {
        logic [3:0] ups;
        logic [3:0] downs;
        song_idx_t  idx;      // song expected after the presses
        sector_t    start;    // first sector of that song
        blk_cnt_t   blocks;   // its length in sectors
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'd0, 4'd1, 2'd3, 32'd400, 8'd4},   // one down from 0 wraps to 3
        '{4'd3, 4'd0, 2'd2, 32'd300, 8'd1},   // wraps up to the one sector song
        '{4'd1, 4'd2, 2'd1, 32'd200, 8'd3},
        '{4'd0, 4'd1, 2'd0, 32'd100, 8'd2}
    };

    logic        clk_25mhz;
    logic        rst;
    logic        btn_up;
    logic        btn_down;
    logic        btn_select;
    sample_t     sd_byte;
    logic        sd_byte_valid;
    logic        block_req;
    sector_t     block_addr;
    song_idx_t   song_index;
    logic        playing;
    logic        serial_out;
    logic [31:0] lfsr = 32'h66cc_d059;
    sector_t     req_q [$];     // sectors requested but not yet delivered
    sample_t     exp_q [$];     // bytes still due on the serial line
    logic        outstanding;   // a sector is being delivered
    int          req_count;
    sector_t     row_start;

    audio_player dut (.*);

    initial begin
        clk_25mhz = 1'b0;
        forever #(CLK_NS / 2) clk_25mhz = ~clk_25mhz;
    end

    task automatic abort_sim();
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_with(input string reason);
        $display("%s", reason);
        abort_sim();
    endtask

    task automatic check_index(input song_idx_t got, input song_idx_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_addr(input sector_t got, input sector_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            abort_sim();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic drive_button(input int which, input logic level);
        case (which)
            BTN_UP:   btn_up = level;
            BTN_DOWN: btn_down = level;
            default:  btn_select = level;
        endcase
    endtask

    task automatic press_button(input int which);
        @(posedge clk_25mhz);
        #2;
        drive_button(which, 1'b1);
        @(posedge clk_25mhz);
        #2;
        drive_button(which, 1'b0);   // release leaves one idle cycle before the next press
        @(posedge clk_25mhz);
    endtask

    task automatic wait_playing(input logic level);
        do @(negedge clk_25mhz); while (playing !== level);
    endtask

    // byte b of sector s is the low byte of start + s plus b
    function automatic void load_expected(input sector_t start, input blk_cnt_t blocks);
        exp_q.delete();
        for (int s = 0; s < int'(blocks); s++) begin
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                exp_q.push_back(sample_t'(start[7:0] + s + b));
            end
        end
    endfunction

    task automatic play_row(input row_t row);
        repeat (row.ups) press_button(BTN_UP);
        repeat (row.downs) press_button(BTN_DOWN);
        @(negedge clk_25mhz);
        check_index(song_index, row.idx, "song_index after menu presses");
        load_expected(row.start, row.blocks);
        row_start = row.start;
        req_count = 0;
        press_button(BTN_SELECT);
        wait_playing(1'b1);
        press_button(BTN_UP);       // menu is locked while playing
        press_button(BTN_SELECT);
        @(negedge clk_25mhz);
        check_index(song_index, row.idx, "song_index during playback");
        wait_playing(1'b0);
        check_flag(exp_q.size() <= 1, 1'b1, "playing fell before the last frame");
        check_flag(req_count == int'(row.blocks), 1'b1,
                   $sformatf("sector count, %0d requested", req_count));
        while (exp_q.size() != 0) @(negedge clk_25mhz);
        repeat (2 * FRAME_BITS * BIT_DIV) begin
            @(negedge clk_25mhz);
            check_flag(serial_out, 1'b0, "serial_out after the last frame");
        end
    endtask

    // sd reader model picks up each request here
    initial begin
        forever begin
            @(negedge clk_25mhz);
            if (!rst && block_req === 1'b1) begin
                check_flag(outstanding, 1'b0, "block_req with a sector still incomplete");
                check_addr(block_addr, row_start + sector_t'(req_count), "block_addr");
                req_q.push_back(block_addr);
                outstanding = 1'b1;
                req_count++;
            end
        end
    end

    // sd reader data side drives everything 2 ns after the edge
    initial begin
        sector_t addr;
        forever begin
            @(posedge clk_25mhz);
            if (req_q.size() != 0) begin
                addr = req_q.pop_front();
                #2;
                repeat (random_bits(4)) begin   // access delay 0..15
                    @(posedge clk_25mhz);
                    #2;
                end
                for (int off = 0; off < BLOCK_BYTES; off++) begin
                    repeat (random_bits(2)) begin   // gap 0..3
                        sd_byte_valid = 1'b0;
                        @(posedge clk_25mhz);
                        #2;
                    end
                    sd_byte       = sample_t'(addr[7:0] + off);
                    sd_byte_valid = 1'b1;
                    @(posedge clk_25mhz);
                    #2;
                end
                sd_byte_valid = 1'b0;
                outstanding   = 1'b0;   // 512th byte taken
            end
        end
    end

    // frame decoder samples each bit once on a falling edge
    initial begin
        logic [FRAME_BITS-1:0] bits;
        logic [SYNC_BITS-1:0]  sync;
        logic [PAD_BITS-1:0]   pad;
        sample_t               data;
        forever begin
            @(negedge clk_25mhz);
            if (serial_out === 1'b1) begin
                bits = {{(FRAME_BITS - 1){1'b0}}, 1'b1};   // first sync bit
                repeat (FRAME_BITS - 1) begin
                    repeat (BIT_DIV) @(negedge clk_25mhz);
                    bits = {bits[FRAME_BITS-2:0], serial_out};
                end
                sync = bits[FRAME_BITS-1 -: SYNC_BITS];
                data = {<<{bits[FRAME_BITS-SYNC_BITS-1 -: SAMPLE_BITS]}};   // sent lsb first
                pad  = bits[PAD_BITS-1:0];
                check_flag(sync == 4'b1011, 1'b1, $sformatf("sync nibble %b", sync));
                check_flag(pad == '0, 1'b1, $sformatf("padding %b", pad));
                if (exp_q.size() == 0) begin
                    fail_with("a frame arrived when no data byte was due");
                end
                check_sample(data, exp_q.pop_front(), "frame data byte");
            end
        end
    end

    // twice the time for one frame per byte of all rows plus 1 ms
    initial begin
        longint limit_ns;
        limit_ns = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit_ns += longint'(ROWS[r].blocks) * BLOCK_BYTES;
        end
        limit_ns = limit_ns * FRAME_BITS * BIT_DIV * CLK_NS * 2 + 1_000_000;
        #(limit_ns);
        fail_with("timeout, the run did not finish in time");
    end

    initial begin
        rst           = 1'b1;
        btn_up        = 1'b0;
        btn_down      = 1'b0;
        btn_select    = 1'b0;
        sd_byte       = '0;
        sd_byte_valid = 1'b0;
        outstanding   = 1'b0;
        req_count     = 0;
        row_start     = '0;
        repeat (5) @(posedge clk_25mhz);
        #2;
        rst = 1'b0;
        @(negedge clk_25mhz);
        check_flag(playing, 1'b0, "playing after reset");
        check_flag(block_req, 1'b0, "block_req after reset");
        check_flag(serial_out, 1'b0, "serial_out after reset");
        check_index(song_index, 2'd0, "song_index after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            play_row(ROWS[r]);
        end
        if (req_q.size() == 0 && !outstanding && exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_with("sectors or data bytes left over at the end of the run");
        end
    end

endmodule
